//--- Bender.yml
package:
  name: rob_backend

sources:
  - include_dirs:
      - .
    files:
      - rob_pkg.sv
      - rob_retire_select.sv
      - reorder_buffer.sv
      - rob_flush_ctrl.sv
      - rob_backend.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rob_backend.sv

//--- build.f
+incdir+.
rob_pkg.sv
rob_retire_select.sv
reorder_buffer.sv
rob_flush_ctrl.sv
rob_backend.sv
tb_rob_backend.sv

//--- reorder_buffer.sv
// Reorder buffer: circular entry storage with wrap-bit head/tail pointers.
// Allocates up to DECODE_WIDTH entries per cycle, takes COMMIT_WIDTH
// completion strobes and retires in order through rob_retire_select.
// A flush empties it at the next edge.

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module reorder_buffer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    flush,
  input  rob_pkg::rob_alloc_req_t                 alloc_req,
  output rob_pkg::rob_alloc_rsp_t                 alloc_rsp,
  input  rob_pkg::rob_cmt_req_t [`COMMIT_WIDTH-1:0] cmt_req,
  output rob_pkg::rob_retire_t                    retire,
  output rob_pkg::rob_idx_t                       oldest_idx
);

  import rob_pkg::*;

  localparam int IDX_W = `ROB_IDX_WIDTH;

  // ==========================================================================
  // State
  // ==========================================================================
  rob_entry_t rob_q [`ROB_DEPTH];
  rob_ptr_t   head_q, tail_q;
  rob_ptr_t   count_q;

  rob_idx_t                       head_idx;
  rob_ptr_t [`DECODE_WIDTH-1:0]   alloc_ptr;  // Tail plus slot number
  rob_ptr_t                       alloc_num;  // Entries taken this cycle
  rob_ptr_t                       retire_num;
  rob_idx_t [`RETIRE_WIDTH-1:0]   win_idx;
  rob_entry_t [`RETIRE_WIDTH-1:0] window;
  logic [`RETIRE_WIDTH-1:0]       sel_valid;

  assign head_idx   = head_q[IDX_W-1:0];
  assign oldest_idx = head_idx;

  // ==========================================================================
  // Allocation
  // ==========================================================================
  always_comb begin
    alloc_rsp.ready = (count_q <= rob_ptr_t'(`ROB_DEPTH - `DECODE_WIDTH));
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      alloc_ptr[i]              = tail_q + rob_ptr_t'(i);
      alloc_rsp.position_bit[i] = alloc_ptr[i][IDX_W];
      alloc_rsp.rob_idx[i]      = alloc_ptr[i][IDX_W-1:0];
    end
    alloc_num = alloc_rsp.ready ? rob_ptr_t'($countones(alloc_req.valid)) : '0;
  end

  // ==========================================================================
  // Retire window
  // ==========================================================================
  always_comb begin
    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      win_idx[i] = head_idx + rob_idx_t'(i);  // Wraps at ROB_DEPTH
      window[i]  = rob_q[win_idx[i]];
    end
  end

  rob_retire_select rob_retire_select_i (
    .window       (window),
    .count        (count_q),
    .retire_valid (sel_valid)
  );

  assign retire.valid = flush ? '0 : sel_valid;  // Nothing leaves during a flush
  assign retire.entry = window;
  assign retire_num   = rob_ptr_t'($countones(retire.valid));

  // ==========================================================================
  // Pointers and count
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + retire_num;
      tail_q  <= tail_q + alloc_num;
      count_q <= count_q + alloc_num - retire_num;
    end
  end

  // Entry storage, new entries start incomplete
  always_ff @(posedge clk) begin
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      if (alloc_rsp.ready && alloc_req.valid[i]) begin
        rob_q[alloc_ptr[i][IDX_W-1:0]] <= '{pc: alloc_req.pc[i],
                                            kind: alloc_req.kind[i],
                                            default: '0};
      end
    end
    for (int i = 0; i < `COMMIT_WIDTH; i++) begin
      if (cmt_req[i].valid) begin
        rob_q[cmt_req[i].rob_idx].complete    <= 1'b1;
        rob_q[cmt_req[i].rob_idx].exception   <= cmt_req[i].exception;
        rob_q[cmt_req[i].rob_idx].ecode       <= cmt_req[i].ecode;
        rob_q[cmt_req[i].rob_idx].sub_ecode   <= cmt_req[i].sub_ecode;
        rob_q[cmt_req[i].rob_idx].redirect    <= cmt_req[i].redirect;
        rob_q[cmt_req[i].rob_idx].br_target   <= cmt_req[i].br_target;
        rob_q[cmt_req[i].rob_idx].error_vaddr <= cmt_req[i].error_vaddr;
      end
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================
  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    count_q <= rob_ptr_t'(`ROB_DEPTH));

  for (genvar g = 0; g < `COMMIT_WIDTH; g++) begin : g_cmt_chk
    rob_idx_t cmt_ofs;  // Distance from head
    assign cmt_ofs = cmt_req[g].rob_idx - head_idx;

    a_cmt_live: assert property (@(posedge clk) disable iff (!rst_n || flush)
      cmt_req[g].valid |-> (rob_ptr_t'(cmt_ofs) < count_q));

    for (genvar h = g + 1; h < `COMMIT_WIDTH; h++) begin : g_pair
      a_cmt_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        (cmt_req[g].valid && cmt_req[h].valid) |->
          (cmt_req[g].rob_idx != cmt_req[h].rob_idx));
    end
  end

endmodule

`default_nettype wire

//--- rob_backend.sv
// Top level of the retirement backend.
// Connects the reorder buffer to the flush controller and merges the
// external flush with the internal one from retiring redirects/exceptions.

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_backend (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      ext_flush,
  input  rob_pkg::rob_alloc_req_t                   alloc_req,
  output rob_pkg::rob_alloc_rsp_t                   alloc_rsp,
  input  rob_pkg::rob_cmt_req_t [`COMMIT_WIDTH-1:0] cmt_req,
  output rob_pkg::rob_retire_t                      retire,
  output rob_pkg::rob_idx_t                         oldest_idx,
  output rob_pkg::flush_info_t                      flush_info
);

  logic rob_flush;  // Either source empties the ROB

  assign rob_flush = ext_flush | flush_info.valid;

  // ==========================================================================
  // Reorder buffer
  // ==========================================================================
  reorder_buffer reorder_buffer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (rob_flush),
    .alloc_req  (alloc_req),
    .alloc_rsp  (alloc_rsp),
    .cmt_req    (cmt_req),
    .retire     (retire),
    .oldest_idx (oldest_idx)
  );

  // ==========================================================================
  // Flush generation
  // ==========================================================================
  rob_flush_ctrl rob_flush_ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .retire     (retire),
    .flush_info (flush_info)
  );

endmodule

`default_nettype wire

//--- rob_flush_ctrl.sv
// Flush controller. Watches the retire port and turns the oldest retiring
// redirect or exception into a registered one-cycle flush record.

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_flush_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rob_pkg::rob_retire_t retire,
  output rob_pkg::flush_info_t flush_info
);

  import rob_pkg::*;

  flush_info_t flush_d;
  flush_info_t rec_q;    // Payload of the last flush
  logic        valid_q;

  // Scan youngest to oldest so the oldest hit wins
  always_comb begin
    flush_d = '0;
    for (int i = `RETIRE_WIDTH - 1; i >= 0; i--) begin
      if (retire.valid[i] && (retire.entry[i].exception || retire.entry[i].redirect)) begin
        flush_d.valid        = 1'b1;
        flush_d.is_exception = retire.entry[i].exception;  // Beats redirect
        flush_d.target       = retire.entry[i].exception ? retire.entry[i].pc
                                                         : retire.entry[i].br_target;
        flush_d.ecode        = retire.entry[i].ecode;
        flush_d.sub_ecode    = retire.entry[i].sub_ecode;
        flush_d.error_vaddr  = retire.entry[i].error_vaddr;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= flush_d.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (flush_d.valid) begin
      rec_q <= flush_d;
    end
  end

  always_comb begin
    flush_info       = rec_q;
    flush_info.valid = valid_q;
  end

  // ROB gates retirement during the pulse, so it cannot retrigger
  a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    valid_q |=> !valid_q);

endmodule

`default_nettype wire

//--- rob_params.svh
// Sizing macros shared by the ROB backend package, RTL and testbench.
// Include this header wherever a width or depth is needed.
// ROB_DEPTH must stay a power of two so that the index wraps naturally.

`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Number of ROB entries
`define ROB_DEPTH 16

// Entry index width; pointers carry one more bit for the wrap position
`define ROB_IDX_WIDTH ($clog2(`ROB_DEPTH))

`define DECODE_WIDTH 2  // Allocation slots per cycle
`define COMMIT_WIDTH 2  // Completion ports
`define RETIRE_WIDTH 2  // Retire slots per cycle

// PC, branch target and faulting address
`define VADDR_WIDTH 32

`endif

//--- rob_pkg.sv
// Types for the ROB backend: instruction kinds, allocation, completion,
// stored entries, the retire bundle and the flush record.
// Modules import it inside their bodies and use scoped names on ports.

`default_nettype none

`include "rob_params.svh"

package rob_pkg;

  typedef logic [`ROB_IDX_WIDTH-1:0] rob_idx_t;  // Entry index
  typedef logic [`ROB_IDX_WIDTH:0]   rob_ptr_t;  // {wrap, index}, also the count
  typedef logic [`VADDR_WIDTH-1:0]   vaddr_t;
  typedef logic [5:0]                ecode_t;
  typedef logic [8:0]                sub_ecode_t;

  typedef enum logic [1:0] {
    KIND_ALU    = 2'd0,
    KIND_BRANCH = 2'd1,
    KIND_LOAD   = 2'd2,
    KIND_STORE  = 2'd3
  } instr_kind_e;

  // ==========================================================================
  // Decode side
  // ==========================================================================
  typedef struct packed {
    logic [`DECODE_WIDTH-1:0]        valid;  // Packed from slot 0 up
    vaddr_t [`DECODE_WIDTH-1:0]      pc;
    instr_kind_e [`DECODE_WIDTH-1:0] kind;
  } rob_alloc_req_t;

  typedef struct packed {
    logic                           ready;
    logic [`DECODE_WIDTH-1:0]       position_bit;
    rob_idx_t [`DECODE_WIDTH-1:0]   rob_idx;
  } rob_alloc_rsp_t;

  // ==========================================================================
  // Execution results and stored entries
  // ==========================================================================
  typedef struct packed {
    logic       valid;
    rob_idx_t   rob_idx;
    logic       exception;
    ecode_t     ecode;
    sub_ecode_t sub_ecode;
    logic       redirect;
    vaddr_t     br_target;
    vaddr_t     error_vaddr;
  } rob_cmt_req_t;

  typedef struct packed {
    vaddr_t      pc;
    instr_kind_e kind;
    logic        complete;
    logic        exception;
    ecode_t      ecode;
    sub_ecode_t  sub_ecode;
    logic        redirect;
    vaddr_t      br_target;
    vaddr_t      error_vaddr;
  } rob_entry_t;

  typedef struct packed {
    logic [`RETIRE_WIDTH-1:0]       valid;
    rob_entry_t [`RETIRE_WIDTH-1:0] entry;  // Slot 0 is the head
  } rob_retire_t;

  typedef struct packed {
    logic       valid;
    logic       is_exception;
    vaddr_t     target;       // Faulting PC or redirect target
    ecode_t     ecode;
    sub_ecode_t sub_ecode;
    vaddr_t     error_vaddr;
  } flush_info_t;

endpackage

`default_nettype wire

//--- rob_retire_select.sv
// Retire window selector for the reorder buffer.
// Takes the oldest RETIRE_WIDTH entries and the occupancy count and
// returns the mask of slots allowed to retire this cycle.

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_retire_select (
  input  rob_pkg::rob_entry_t [`RETIRE_WIDTH-1:0] window,
  input  rob_pkg::rob_ptr_t                       count,
  output logic [`RETIRE_WIDTH-1:0]                retire_valid
);

  import rob_pkg::*;

  always_comb begin
    logic chain;         // All older slots retire
    logic stop_seen;     // Older slot redirects or faults
    logic branch_seen;   // Older slot is a branch
    logic is_branch;
    logic slot_ok;

    chain       = 1'b1;
    stop_seen   = 1'b0;
    branch_seen = 1'b0;
    retire_valid = '0;

    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      is_branch = (window[i].kind == KIND_BRANCH);
      slot_ok   = (i < count) && window[i].complete;

      if (i > 0) begin
        // Younger slots: in-order, one branch, stores only at head
        slot_ok = slot_ok && !stop_seen && !(branch_seen && is_branch) &&
                  (window[i].kind != KIND_STORE);
      end

      chain = chain && slot_ok;
      retire_valid[i] = chain;

      stop_seen   = stop_seen | window[i].redirect | window[i].exception;
      branch_seen = branch_seen | is_branch;
    end
  end

  // ==========================================================================
  // Checks
  // ==========================================================================

  // Mask must be a run of ones starting at the head slot
  a_mask_contig: assert final (((retire_valid + 1'b1) & retire_valid) == '0)
    else $error("retire mask not contiguous from slot 0");

  // Never retire entries the ROB does not hold
  a_mask_le_count: assert final ($countones(retire_valid) <= count)
    else $error("retire mask exceeds ROB count");

endmodule

`default_nettype wire

//--- tb_rob_backend.sv
// Directed testbench for the ROB retirement backend.
// A queue model mirrors the ROB contents and pointers; each test task
// drives allocation, completion and flush on falling edges and checks
// the allocation response, the retire port and the flush record.

`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module tb_rob_backend;

  import rob_pkg::*;

  localparam int WAIT_LIMIT = 20;  // Cycles allowed for any wait

  logic                                clk;
  logic                                rst_n;
  logic                                ext_flush;
  rob_alloc_req_t                      alloc_req;
  rob_alloc_rsp_t                      alloc_rsp;
  rob_cmt_req_t [`COMMIT_WIDTH-1:0]    cmt_req;
  rob_retire_t                         retire;
  rob_idx_t                            oldest_idx;
  flush_info_t                         flush_info;

  rob_entry_t  model_q[$];   // Head of the ROB at index 0
  int          head_ptr;     // Model pointers including the wrap bit
  int          tail_ptr;
  int          errors;
  int          tests_run;
  logic [31:0] rng_state;

  rob_backend rob_backend_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ext_flush  (ext_flush),
    .alloc_req  (alloc_req),
    .alloc_rsp  (alloc_rsp),
    .cmt_req    (cmt_req),
    .retire     (retire),
    .oldest_idx (oldest_idx),
    .flush_info (flush_info)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================================
  // Model and stimulus helpers
  // ==========================================================================
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic rob_alloc_rsp_t expected_rsp();
    rob_alloc_rsp_t rsp;
    rsp.ready = (model_q.size() <= `ROB_DEPTH - `DECODE_WIDTH);
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      rsp.rob_idx[i]      = rob_idx_t'((tail_ptr + i) % `ROB_DEPTH);
      rsp.position_bit[i] = ((tail_ptr + i) / `ROB_DEPTH) % 2;
    end
    return rsp;
  endfunction

  task automatic reset_model();
    model_q.delete();
    head_ptr = 0;
    tail_ptr = 0;
  endtask

  // ==========================================================================
  // Compare tasks
  // ==========================================================================
  task automatic check_alloc_rsp(input rob_alloc_rsp_t got, input rob_alloc_rsp_t exp,
                                 input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, alloc_rsp %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_retire(input rob_retire_t got, input rob_retire_t exp,
                              input string what);
    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      if (!exp.valid[i]) begin  // Idle slots carry don't-care entries
        got.entry[i] = '0;
        exp.entry[i] = '0;
      end
    end
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, retire valid %b pc %h/%h expected %b pc %h/%h",
               $time, what, got.valid, got.entry[0].pc, got.entry[1].pc,
               exp.valid, exp.entry[0].pc, exp.entry[1].pc);
    end
  endtask

  task automatic check_flush(input flush_info_t got, input flush_info_t exp,
                             input string what);
    if ((exp.valid && got !== exp) || (!exp.valid && got.valid !== 1'b0)) begin
      errors++;
      $display("Mismatch at %0t ns: %s, flush_info %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_oldest_idx(input rob_idx_t got, input rob_idx_t exp,
                                  input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, oldest_idx %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ==========================================================================
  // Driving tasks
  // ==========================================================================
  task automatic alloc_bundle(input int n, input instr_kind_e k0, input instr_kind_e k1,
                              input string what);
    rob_alloc_rsp_t exp;
    rob_entry_t     e;
    exp = expected_rsp();
    check_alloc_rsp(alloc_rsp, exp, what);
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      alloc_req.valid[i] = (i < n);
      alloc_req.pc[i]    = next_random();
    end
    alloc_req.kind[0] = k0;
    alloc_req.kind[1] = k1;
    @(negedge clk);
    if (exp.ready) begin  // Held requests are not recorded
      for (int i = 0; i < n; i++) begin
        e      = '0;
        e.pc   = alloc_req.pc[i];
        e.kind = alloc_req.kind[i];
        model_q.push_back(e);
      end
      tail_ptr = (tail_ptr + n) % (2 * `ROB_DEPTH);
    end
    alloc_req.valid = '0;
  endtask

  // One completion strobe for the entry at model position pos
  task automatic complete_entry(input int port, input int pos, input logic exc,
                                input ecode_t ecode, input sub_ecode_t sub,
                                input logic redir, input vaddr_t target, input vaddr_t evaddr);
    cmt_req[port].valid       = 1'b1;
    cmt_req[port].rob_idx     = rob_idx_t'((head_ptr + pos) % `ROB_DEPTH);
    cmt_req[port].exception   = exc;
    cmt_req[port].ecode       = ecode;
    cmt_req[port].sub_ecode   = sub;
    cmt_req[port].redirect    = redir;
    cmt_req[port].br_target   = target;
    cmt_req[port].error_vaddr = evaddr;
    model_q[pos].complete    = 1'b1;
    model_q[pos].exception   = exc;
    model_q[pos].ecode       = ecode;
    model_q[pos].sub_ecode   = sub;
    model_q[pos].redirect    = redir;
    model_q[pos].br_target   = target;
    model_q[pos].error_vaddr = evaddr;
    @(negedge clk);
    cmt_req[port] = '0;
  endtask

  task automatic complete_ok(input int pos);
    complete_entry(pos % `COMMIT_WIDTH, pos, 1'b0, '0, '0, 1'b0, '0, '0);
  endtask

  // Waits for a retirement, checks it against the model head and pops
  task automatic expect_retire(input logic [`RETIRE_WIDTH-1:0] mask, input string what);
    rob_retire_t exp;
    int          waited;
    waited = 0;
    while (retire.valid == '0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (retire.valid == '0) begin
      errors++;
      $display("Timeout: %s, nothing retired within %0d cycles", what, WAIT_LIMIT);
    end else begin
      exp       = '0;
      exp.valid = mask;
      for (int i = 0; i < `RETIRE_WIDTH; i++) begin
        if (mask[i] && i < model_q.size()) exp.entry[i] = model_q[i];
      end
      check_oldest_idx(oldest_idx, rob_idx_t'(head_ptr % `ROB_DEPTH), what);
      check_retire(retire, exp, what);
      for (int i = 0; i < `RETIRE_WIDTH; i++) begin
        if (mask[i] && model_q.size() > 0) begin
          void'(model_q.pop_front());
          head_ptr = (head_ptr + 1) % (2 * `ROB_DEPTH);
        end
      end
      @(negedge clk);
    end
  endtask

  task automatic expect_flush(input flush_info_t exp, input string what);
    int waited;
    waited = 0;
    while (!flush_info.valid && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!flush_info.valid) begin
      errors++;
      $display("Timeout: %s, no flush pulse within %0d cycles", what, WAIT_LIMIT);
    end else begin
      check_flush(flush_info, exp, what);
      check_retire(retire, '0, {what, " during flush"});
      @(negedge clk);
      reset_model();
      check_oldest_idx(oldest_idx, '0, {what, " empties ROB"});
    end
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles) begin
      check_retire(retire, '0, what);
      @(negedge clk);
    end
  endtask

  // Completes everything youngest first, then retires it all (ALU/load only)
  task automatic drain(input string what);
    int rounds;
    for (int i = model_q.size() - 1; i >= 0; i--) complete_ok(i);
    rounds = 0;
    while (model_q.size() > 0 && rounds < `ROB_DEPTH) begin
      expect_retire((model_q.size() > 1) ? 2'b11 : 2'b01, what);
      rounds++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    tests_run++;
    if (errors == start_err) $display("[test] %s: ok", name);
    else $display("[test] %s: %0d errors", name, errors - start_err);
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================
  task automatic test_reset_state();
    int start_err;
    start_err = errors;
    check_alloc_rsp(alloc_rsp, expected_rsp(), "reset response");
    check_retire(retire, '0, "reset retire");
    check_flush(flush_info, '0, "reset flush");
    check_oldest_idx(oldest_idx, '0, "reset oldest index");
    report_test("reset state", start_err);
  endtask

  task automatic test_alloc_backpressure();
    int start_err;
    start_err = errors;
    alloc_bundle(1, KIND_ALU, KIND_ALU, "single alloc");
    alloc_bundle(2, KIND_ALU, KIND_LOAD, "dual alloc");
    alloc_bundle(1, KIND_LOAD, KIND_ALU, "single alloc");
    while (model_q.size() <= `ROB_DEPTH - `DECODE_WIDTH) begin
      alloc_bundle(2, KIND_ALU, KIND_ALU, "fill");
    end
    alloc_bundle(2, KIND_ALU, KIND_ALU, "held while full");
    alloc_bundle(2, KIND_ALU, KIND_ALU, "held while full");
    complete_ok(1);
    complete_ok(0);
    expect_retire(2'b11, "free two entries");
    alloc_bundle(2, KIND_LOAD, KIND_ALU, "alloc after wrap");  // Index 0 with the wrap bit set
    drain("drain full ROB");
    report_test("allocation and back-pressure", start_err);
  endtask

  task automatic test_in_order();
    int start_err;
    start_err = errors;
    alloc_bundle(2, KIND_ALU, KIND_LOAD, "alloc");
    alloc_bundle(2, KIND_LOAD, KIND_ALU, "alloc");
    alloc_bundle(1, KIND_ALU, KIND_ALU, "alloc");
    for (int i = model_q.size() - 1; i > 0; i--) complete_ok(i);
    expect_quiet(3, "head not complete");
    complete_ok(0);
    expect_retire(2'b11, "in-order pair");
    expect_retire(2'b11, "in-order pair");
    expect_retire(2'b01, "last entry");
    report_test("in-order retirement", start_err);
  endtask

  task automatic test_branch_store();
    int start_err;
    start_err = errors;
    alloc_bundle(2, KIND_BRANCH, KIND_BRANCH, "two branches");
    complete_ok(1);
    complete_ok(0);
    expect_retire(2'b01, "first branch alone");
    expect_retire(2'b01, "second branch");
    alloc_bundle(2, KIND_ALU, KIND_STORE, "alu then store");
    complete_ok(1);
    complete_ok(0);
    expect_retire(2'b01, "store held behind alu");
    expect_retire(2'b01, "store from slot 0");
    report_test("branch and store limits", start_err);
  endtask

  task automatic test_redirect_flush();
    flush_info_t exp;
    vaddr_t      target;
    int          start_err;
    start_err = errors;
    target    = next_random();
    alloc_bundle(2, KIND_BRANCH, KIND_ALU, "branch and alu");
    alloc_bundle(1, KIND_ALU, KIND_ALU, "younger alu");
    complete_ok(2);
    complete_ok(1);
    complete_entry(0, 0, 1'b0, '0, '0, 1'b1, target, '0);
    expect_retire(2'b01, "redirecting branch alone");
    exp        = '0;
    exp.valid  = 1'b1;
    exp.target = target;
    expect_flush(exp, "redirect flush");
    expect_quiet(2, "after redirect flush");
    alloc_bundle(1, KIND_ALU, KIND_ALU, "alloc after flush");
    drain("drain after redirect");
    report_test("redirect flush", start_err);
  endtask

  task automatic test_exception_flush();
    flush_info_t exp;
    vaddr_t      evaddr;
    int          start_err;
    start_err = errors;
    evaddr    = next_random();
    alloc_bundle(2, KIND_ALU, KIND_LOAD, "alu and load");
    exp              = '0;
    exp.valid        = 1'b1;
    exp.is_exception = 1'b1;
    exp.target       = model_q[1].pc;  // Faulting load's own PC
    exp.ecode        = 6'h0d;
    exp.sub_ecode    = 9'h1a5;
    exp.error_vaddr  = evaddr;
    complete_entry(1, 1, 1'b1, exp.ecode, exp.sub_ecode, 1'b0, '0, evaddr);
    complete_ok(0);
    expect_retire(2'b11, "alu and faulting load");
    expect_flush(exp, "exception flush");

    // External flush
    alloc_bundle(2, KIND_ALU, KIND_ALU, "alloc before external flush");
    alloc_bundle(1, KIND_LOAD, KIND_ALU, "alloc before external flush");
    ext_flush = 1'b1;
    @(negedge clk);
    ext_flush = 1'b0;
    check_flush(flush_info, '0, "external flush leaves flush_info idle");
    reset_model();
    alloc_bundle(1, KIND_ALU, KIND_ALU, "alloc after external flush");
    drain("drain after external flush");
    report_test("exception and external flush", start_err);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    rst_n     = 1'b0;
    ext_flush = 1'b0;
    alloc_req = '0;
    cmt_req   = '0;
    rng_state = 32'h600c4e20;
    errors    = 0;
    tests_run = 0;
    reset_model();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_state();
    test_alloc_backpressure();
    test_in_order();
    test_branch_store();
    test_redirect_flush();
    test_exception_flush();

    $display("Summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
